/* sources.f */
rv_isa_pkg.sv
pipe_pkg.sv
pipe_if.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
mem_wb_stage.sv
rv_pipe_top.sv
tb_rv_pipe.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_rv_pipe -f sources.f \
    || { echo "Verilator build failed"; exit 1; }

out="$(./obj_dir/Vtb_rv_pipe)"
echo "$out"
grep -qF "=== PASS ===" <<< "$out" && exit 0 || exit 1

/* tb_rv_pipe.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_rv_pipe;
    import rv_isa_pkg::*;

    localparam int IMEM_DEPTH   = 64;
    localparam int DMEM_DEPTH   = 64;
    localparam int IADDR_W      = $clog2(IMEM_DEPTH);
    localparam int DADDR_W      = $clog2(DMEM_DEPTH);
    localparam int PROG_LEN     = 40;
    localparam int NUM_PROGRAMS = 3;
    localparam int HALT_TIMEOUT = 400;

    // Instruction kinds for the generator and model
    localparam int K_ADD     = 0;
    localparam int K_SUB     = 1;
    localparam int K_AND     = 2;
    localparam int K_OR      = 3;
    localparam int K_XOR     = 4;
    localparam int K_SLT     = 5;
    localparam int K_ADDI    = 6;
    localparam int K_ANDI    = 7;
    localparam int K_ORI     = 8;
    localparam int K_XORI    = 9;
    localparam int K_LUI     = 10;
    localparam int K_LW      = 11;
    localparam int K_SW      = 12;
    localparam int NUM_KINDS = 13;

    logic               clk;
    logic               i_rst_n;
    logic               i_imem_we;
    logic [IADDR_W-1:0] i_imem_addr;
    logic [XLEN-1:0]    i_imem_data;
    logic               i_start;
    logic               o_wb_valid;
    logic [4:0]         o_wb_rd;
    logic [XLEN-1:0]    o_wb_data;
    logic               o_halted;

    logic [31:0]     rand_state;
    int              value_errs;
    int              other_errs;
    bit              timed_out;
    bit              started;
    int              wb_count;
    int              exp_total;
    logic [4:0]      exp_rd [$];
    logic [XLEN-1:0] exp_data [$];
    logic [XLEN-1:0] model_mem [DMEM_DEPTH];

    int              p_kind [PROG_LEN];
    logic [4:0]      p_rd [PROG_LEN];
    logic [4:0]      p_rs1 [PROG_LEN];
    logic [4:0]      p_rs2 [PROG_LEN];
    logic [XLEN-1:0] p_imm [PROG_LEN];
    instr_word_t     prog_words [PROG_LEN+1];

    rv_pipe_top #(
        .IMEM_DEPTH (IMEM_DEPTH),
        .DMEM_DEPTH (DMEM_DEPTH)
    ) dut_i (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_imem_we   (i_imem_we),
        .i_imem_addr (i_imem_addr),
        .i_imem_data (i_imem_data),
        .i_start     (i_start),
        .o_wb_valid  (o_wb_valid),
        .o_wb_rd     (o_wb_rd),
        .o_wb_data   (o_wb_data),
        .o_halted    (o_halted)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    // Upper bits only, low LCG bits repeat quickly
    function automatic int rand_below(input int n);
        return int'((lcg_next() >> 16) % 32'(n));
    endfunction

    // x0..x7 keeps hazards frequent
    function automatic logic [4:0] rand_reg();
        return 5'(rand_below(8));
    endfunction

    function automatic logic [2:0] kind_funct3(input int kind);
        case (kind)
            K_AND, K_ANDI: return F3_AND;
            K_OR, K_ORI:   return F3_OR;
            K_XOR, K_XORI: return F3_XOR;
            K_SLT:         return F3_SLT;
            default:       return F3_ADD;
        endcase
    endfunction

    function automatic instr_word_t encode(input int kind, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic [XLEN-1:0] imm);
        instr_word_t w;
        w = '0;
        case (kind)
            K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT:
            begin
                w.r_fmt.opcode = OPC_OP;
                w.r_fmt.funct7 = (kind == K_SUB) ? F7_SUB : 7'd0;
                w.r_fmt.funct3 = kind_funct3(kind);
                w.r_fmt.rd     = rd;
                w.r_fmt.rs1    = rs1;
                w.r_fmt.rs2    = rs2;
            end
            K_ADDI, K_ANDI, K_ORI, K_XORI, K_LW:
            begin
                w.i_fmt.opcode = (kind == K_LW) ? OPC_LOAD : OPC_OP_IMM;
                w.i_fmt.funct3 = (kind == K_LW) ? F3_WORD : kind_funct3(kind);
                w.i_fmt.rd     = rd;
                w.i_fmt.rs1    = rs1;
                w.i_fmt.imm12  = imm[11:0];
            end
            K_LUI:
            begin
                // Upper immediate spread over imm12, rs1 and funct3
                w.i_fmt.opcode = OPC_LUI;
                w.i_fmt.rd     = rd;
                w.i_fmt.imm12  = imm[31:20];
                w.i_fmt.rs1    = imm[19:15];
                w.i_fmt.funct3 = imm[14:12];
            end
            K_SW:
            begin
                w.r_fmt.opcode = OPC_STORE;
                w.r_fmt.funct3 = F3_WORD;
                w.r_fmt.funct7 = imm[11:5];
                w.r_fmt.rd     = imm[4:0];
                w.r_fmt.rs1    = rs1;
                w.r_fmt.rs2    = rs2;
            end
            default:
                w = HALT_INSTR;
        endcase
        return w;
    endfunction

    task automatic set_instr(input int idx, input int kind, input logic [4:0] rd,
                             input logic [4:0] rs1, input logic [4:0] rs2,
                             input logic [XLEN-1:0] imm);
        p_kind[idx]     = kind;
        p_rd[idx]       = rd;
        p_rs1[idx]      = rs1;
        p_rs2[idx]      = rs2;
        p_imm[idx]      = imm;
        prog_words[idx] = encode(kind, rd, rs1, rs2, imm);
    endtask

    task automatic gen_program();
        int              i;
        int              kind;
        logic [4:0]      a;
        logic [4:0]      b;
        logic [4:0]      c;
        logic [31:0]     r;
        logic [XLEN-1:0] off;
        logic [XLEN-1:0] imm;
        i = 0;
        while (i < PROG_LEN)
        begin
            kind = rand_below(NUM_KINDS + 1);
            a    = rand_reg();
            b    = rand_reg();
            c    = rand_reg();
            off  = XLEN'(rand_below(DMEM_DEPTH) * 4);
            r    = lcg_next();
            if (kind == NUM_KINDS && i + 3 <= PROG_LEN)
            begin
                // Store, reload, then use the loaded value at once
                set_instr(i, K_SW, 5'd0, 5'd0, b, off);
                set_instr(i + 1, K_LW, a, 5'd0, 5'd0, off);
                set_instr(i + 2, K_ADD, c, a, b, '0);
                i += 3;
            end
            else
            begin
                kind = kind % NUM_KINDS;
                case (kind)
                    K_LW, K_SW:
                    begin
                        b   = 5'd0;
                        imm = off;
                    end
                    K_LUI:
                        imm = {r[31:12], 12'b0};
                    default:
                        imm = {{20{r[27]}}, r[27:16]};
                endcase
                set_instr(i, kind, a, b, c, imm);
                i++;
            end
        end
        prog_words[PROG_LEN] = HALT_INSTR;
    endtask

    // In-order ISA model; data memory persists across programs like the DUT's
    task automatic run_model();
        logic [XLEN-1:0] model_regs [8];
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] v;
        logic [XLEN-1:0] addr;
        bit              writes;
        for (int r = 0; r < 8; r++)
            model_regs[r] = '0;
        for (int i = 0; i < PROG_LEN; i++)
        begin
            a      = model_regs[p_rs1[i][2:0]];
            b      = model_regs[p_rs2[i][2:0]];
            addr   = a + p_imm[i];
            writes = 1'b1;
            v      = '0;
            case (p_kind[i])
                K_ADD:  v = a + b;
                K_SUB:  v = a - b;
                K_AND:  v = a & b;
                K_OR:   v = a | b;
                K_XOR:  v = a ^ b;
                K_SLT:  v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                K_ADDI: v = a + p_imm[i];
                K_ANDI: v = a & p_imm[i];
                K_ORI:  v = a | p_imm[i];
                K_XORI: v = a ^ p_imm[i];
                K_LUI:  v = p_imm[i];
                K_LW:   v = model_mem[addr[DADDR_W+1:2]];
                K_SW:
                begin
                    model_mem[addr[DADDR_W+1:2]] = b;
                    writes = 1'b0;
                end
                default: writes = 1'b0;
            endcase
            if (writes && p_rd[i] != 5'd0)
            begin
                model_regs[p_rd[i][2:0]] = v;
                exp_rd.push_back(p_rd[i]);
                exp_data.push_back(v);
            end
        end
    endtask

    task automatic check_wb(input logic [4:0] got_rd, input logic [XLEN-1:0] got_data,
                            input logic [4:0] want_rd, input logic [XLEN-1:0] want_data);
        if (got_rd !== want_rd || got_data !== want_data)
        begin
            $display("Error at %0t: writeback x%0d = %h, expected x%0d = %h",
                     $time, got_rd, got_data, want_rd, want_data);
            value_errs++;
        end
    endtask

    task automatic check_count(input int got, input int want, input string what);
        if (got != want)
        begin
            $display("Error at %0t: %s count %0d, expected %0d", $time, what, got, want);
            value_errs++;
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk)
    begin
        logic [4:0]      want_rd;
        logic [XLEN-1:0] want_data;
        if (i_rst_n)
        begin
            if (!started && (o_wb_valid || o_halted))
            begin
                $display("Writeback or halt seen while the core was idle at %0t", $time);
                other_errs++;
            end
            else if (o_wb_valid)
            begin
                wb_count++;
                if (o_halted)
                begin
                    $display("Writeback to x%0d arrived after halt at %0t", o_wb_rd, $time);
                    other_errs++;
                end
                if (exp_rd.size() == 0)
                begin
                    $display("Unexpected extra writeback to x%0d at %0t", o_wb_rd, $time);
                    other_errs++;
                end
                else
                begin
                    want_rd   = exp_rd.pop_front();
                    want_data = exp_data.pop_front();
                    check_wb(o_wb_rd, o_wb_data, want_rd, want_data);
                end
            end
        end
    end

    task automatic apply_reset();
        started = 1'b0;
        i_rst_n   <= 1'b0;
        i_start   <= 1'b0;
        i_imem_we <= 1'b0;
        repeat (4) @(posedge clk);
        i_rst_n <= 1'b1;
    endtask

    task automatic load_program();
        for (int i = 0; i <= PROG_LEN; i++)
        begin
            @(posedge clk);
            i_imem_we   <= 1'b1;
            i_imem_addr <= IADDR_W'(i);
            i_imem_data <= prog_words[i];
        end
        @(posedge clk);
        i_imem_we <= 1'b0;
    endtask

    task automatic wait_halted(output bit ok);
        int cycles;
        ok     = 1'b0;
        cycles = 0;
        while (!ok && cycles < HALT_TIMEOUT)
        begin
            @(negedge clk);
            ok = o_halted;
            cycles++;
        end
    endtask

    task automatic run_program(input int prog);
        bit ok;
        exp_rd.delete();
        exp_data.delete();
        wb_count = 0;
        gen_program();
        run_model();
        exp_total = exp_rd.size();
        @(posedge clk);
        apply_reset();
        load_program();
        @(posedge clk);
        i_start <= 1'b1;
        started = 1'b1;
        @(posedge clk);
        i_start <= 1'b0;
        wait_halted(ok);
        if (!ok)
        begin
            $display("Timeout: o_halted did not rise within %0d cycles in program %0d",
                     HALT_TIMEOUT, prog);
            other_errs++;
            timed_out = 1'b1;
        end
        else
        begin
            // Watch for late writebacks after halt
            repeat (8) @(negedge clk);
            check_count(wb_count, exp_total, "writeback");
            $display("Program %0d halted after %0d writebacks", prog, wb_count);
        end
    endtask

    initial
    begin
        rand_state = 32'hd1ad;
        value_errs = 0;
        other_errs = 0;
        timed_out  = 1'b0;
        started    = 1'b0;
        wb_count   = 0;
        for (int i = 0; i < DMEM_DEPTH; i++)
            model_mem[i] = '0;
        i_rst_n     <= 1'b0;
        i_imem_we   <= 1'b0;
        i_imem_addr <= '0;
        i_imem_data <= '0;
        i_start     <= 1'b0;
        for (int p = 0; p < NUM_PROGRAMS; p++)
        begin
            if (!timed_out)
                run_program(p);
        end
        $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0 && !timed_out)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

/* rv_pipe_top.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_pipe_top #(
    parameter int IMEM_DEPTH = 64,
    parameter int DMEM_DEPTH = 64
) (
    input  logic                          clk,
    input  logic                          i_rst_n,
    input  logic                          i_imem_we,
    input  logic [$clog2(IMEM_DEPTH)-1:0] i_imem_addr,
    input  logic [rv_isa_pkg::XLEN-1:0]   i_imem_data,
    input  logic                          i_start,
    output logic                          o_wb_valid,
    output logic [4:0]                    o_wb_rd,
    output logic [rv_isa_pkg::XLEN-1:0]   o_wb_data,
    output logic                          o_halted
);
    import rv_isa_pkg::*;

    instr_word_t     f_instr;
    logic [XLEN-1:0] f_pc;
    logic            f_halt_seen;
    logic            stall;

    id_ex_bus_if  id_ex_bus ();
    ex_mem_bus_if ex_mem_bus ();

    fetch_stage #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) fetch_i (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_imem_we   (i_imem_we),
        .i_imem_addr (i_imem_addr),
        .i_imem_data (i_imem_data),
        .i_start     (i_start),
        .i_stall     (stall),
        .o_instr     (f_instr),
        .o_pc        (f_pc),
        .o_halt_seen (f_halt_seen)
    );

    decode_stage decode_i (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_instr     (f_instr),
        .i_pc        (f_pc),
        .i_halt_seen (f_halt_seen),
        .i_wb_valid  (o_wb_valid),
        .i_wb_rd     (o_wb_rd),
        .i_wb_data   (o_wb_data),
        .o_stall     (stall),
        .o_halted    (o_halted),
        .id_ex       (id_ex_bus.producer)
    );

    // MEM/WB result forwarded back into execute
    execute_stage execute_i (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_wb_valid (o_wb_valid),
        .i_wb_rd    (o_wb_rd),
        .i_wb_data  (o_wb_data),
        .id_ex      (id_ex_bus.consumer),
        .ex_mem     (ex_mem_bus.producer)
    );

    mem_wb_stage #(
        .DMEM_DEPTH (DMEM_DEPTH)
    ) mem_wb_i (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .ex_mem     (ex_mem_bus.consumer),
        .o_wb_valid (o_wb_valid),
        .o_wb_rd    (o_wb_rd),
        .o_wb_data  (o_wb_data)
    );

endmodule

`default_nettype wire

/* mem_wb_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_wb_stage #(
    parameter int DMEM_DEPTH = 64
) (
    input  logic                        clk,
    input  logic                        i_rst_n,
    ex_mem_bus_if.consumer              ex_mem,
    output logic                        o_wb_valid,
    output logic [4:0]                  o_wb_rd,
    output logic [rv_isa_pkg::XLEN-1:0] o_wb_data
);
    import rv_isa_pkg::*;

    localparam int DADDR_W = $clog2(DMEM_DEPTH);

    logic [XLEN-1:0]    dmem [DMEM_DEPTH];
    logic [DADDR_W-1:0] word_addr;
    logic [XLEN-1:0]    load_data;
    logic [XLEN-1:0]    wb_alu;
    logic [XLEN-1:0]    wb_load;
    logic               wb_mem_to_reg;
    logic               wb_reg_write;

    initial
    begin
        for (int i = 0; i < DMEM_DEPTH; i++)
            dmem[i] = '0;
    end

    // Word address drops the byte offset
    assign word_addr = ex_mem.alu_result[DADDR_W+1:2];
    assign load_data = dmem[word_addr];

    always_ff @(posedge clk)
    begin
        if (ex_mem.mem_write)
            dmem[word_addr] <= ex_mem.store_data;
    end

    // MEM/WB
    always_ff @(posedge clk)
    begin
        if (!i_rst_n)
        begin
            wb_mem_to_reg <= 1'b0;
            wb_reg_write  <= 1'b0;
        end
        else
        begin
            wb_mem_to_reg <= ex_mem.mem_to_reg;
            wb_reg_write  <= ex_mem.reg_write;
        end
        wb_alu  <= ex_mem.alu_result;
        wb_load <= load_data;
        o_wb_rd <= ex_mem.rd;
    end

    assign o_wb_valid = wb_reg_write && o_wb_rd != 5'd0;
    assign o_wb_data  = wb_mem_to_reg ? wb_load : wb_alu;

    dmem_in_range: assert property (@(posedge clk) disable iff (!i_rst_n)
        (ex_mem.mem_write || ex_mem.mem_to_reg) |->
            ex_mem.alu_result[XLEN-1:2] < (XLEN-2)'(DMEM_DEPTH));

endmodule

`default_nettype wire

/* execute_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
    input  logic                        clk,
    input  logic                        i_rst_n,
    input  logic                        i_wb_valid,
    input  logic [4:0]                  i_wb_rd,
    input  logic [rv_isa_pkg::XLEN-1:0] i_wb_data,
    id_ex_bus_if.consumer               id_ex,
    ex_mem_bus_if.producer              ex_mem
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] rs2_fwd;
    logic [XLEN-1:0] alu_result;

    // Younger result wins over older
    function automatic logic [XLEN-1:0] forward(input logic [4:0]      idx,
                                                input logic [XLEN-1:0] reg_val);
        if (idx != 5'd0 && ex_mem.reg_write && ex_mem.rd == idx)
            return ex_mem.alu_result;
        if (i_wb_valid && i_wb_rd == idx)
            return i_wb_data;
        return reg_val;
    endfunction

    assign op_a    = forward(id_ex.rs1, id_ex.rs1_data);
    assign rs2_fwd = forward(id_ex.rs2, id_ex.rs2_data);
    assign op_b    = id_ex.alu_src ? id_ex.imm : rs2_fwd;

    always_comb
    begin
        case (id_ex.alu_op)
            ALU_ADD:    alu_result = op_a + op_b;
            ALU_SUB:    alu_result = op_a - op_b;
            ALU_AND:    alu_result = op_a & op_b;
            ALU_OR:     alu_result = op_a | op_b;
            ALU_XOR:    alu_result = op_a ^ op_b;
            ALU_SLT:    alu_result = XLEN'($signed(op_a) < $signed(op_b));
            ALU_PASS_B: alu_result = op_b;
            default:    alu_result = '0;
        endcase
    end

    // EX/MEM register is never stalled
    always_ff @(posedge clk)
    begin
        if (!i_rst_n)
        begin
            ex_mem.mem_write  <= 1'b0;
            ex_mem.mem_to_reg <= 1'b0;
            ex_mem.reg_write  <= 1'b0;
        end
        else
        begin
            ex_mem.mem_write  <= id_ex.mem_write;
            ex_mem.mem_to_reg <= id_ex.mem_to_reg;
            ex_mem.reg_write  <= id_ex.reg_write;
        end
        ex_mem.alu_result <= alu_result;
        ex_mem.store_data <= rs2_fwd;
        ex_mem.rd         <= id_ex.rd;
    end

endmodule

`default_nettype wire

/* decode_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
    input  logic                        clk,
    input  logic                        i_rst_n,
    input  rv_isa_pkg::instr_word_t     i_instr,
    input  logic [rv_isa_pkg::XLEN-1:0] i_pc,
    input  logic                        i_halt_seen,
    input  logic                        i_wb_valid,
    input  logic [4:0]                  i_wb_rd,
    input  logic [rv_isa_pkg::XLEN-1:0] i_wb_data,
    output logic                        o_stall,
    output logic                        o_halted,
    id_ex_bus_if.producer               id_ex
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    localparam int CNT_W = $clog2(DRAIN_CYCLES);

    logic [XLEN-1:0]     regs [32];
    logic [XLEN-1:0]     rs1_data;
    logic [XLEN-1:0]     rs2_data;
    logic [XLEN-1:0]     imm;
    logic [ALU_OP_W-1:0] alu_op;
    logic                alu_src;
    logic                mem_write;
    logic                mem_to_reg;
    logic                reg_write;
    logic                use_rs1;
    logic                use_rs2;
    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [4:0]          rd;
    logic [CNT_W-1:0]    drain_cnt;

    function automatic logic [ALU_OP_W-1:0] f3_to_alu(input logic [2:0] funct3);
        case (funct3)
            F3_ADD:  return ALU_ADD;
            F3_XOR:  return ALU_XOR;
            F3_OR:   return ALU_OR;
            F3_AND:  return ALU_AND;
            F3_SLT:  return ALU_SLT;
            default: return ALU_ADD;
        endcase
    endfunction

    // Write-through so a same-cycle writeback is seen
    function automatic logic [XLEN-1:0] read_reg(input logic [4:0] idx);
        if (idx == 5'd0)
            return '0;
        if (i_wb_valid && i_wb_rd == idx)
            return i_wb_data;
        return regs[idx];
    endfunction

    always_comb
    begin
        alu_op     = ALU_ADD;
        alu_src    = 1'b0;
        imm        = '0;
        mem_write  = 1'b0;
        mem_to_reg = 1'b0;
        reg_write  = 1'b0;
        use_rs1    = 1'b0;
        use_rs2    = 1'b0;
        case (i_instr.r_fmt.opcode)
            OPC_OP:
            begin
                alu_op = f3_to_alu(i_instr.r_fmt.funct3);
                if (i_instr.r_fmt.funct3 == F3_ADD && i_instr.r_fmt.funct7 == F7_SUB)
                    alu_op = ALU_SUB;
                reg_write = 1'b1;
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
            end
            OPC_OP_IMM:
            begin
                alu_op    = f3_to_alu(i_instr.i_fmt.funct3);
                alu_src   = 1'b1;
                imm       = {{(XLEN-12){i_instr.i_fmt.imm12[11]}}, i_instr.i_fmt.imm12};
                reg_write = 1'b1;
                use_rs1   = 1'b1;
            end
            OPC_LUI:
            begin
                alu_op    = ALU_PASS_B;
                alu_src   = 1'b1;
                imm       = {i_instr.i_fmt.imm12, i_instr.i_fmt.rs1, i_instr.i_fmt.funct3,
                             12'b0};
                reg_write = 1'b1;
            end
            OPC_LOAD:
            begin
                if (i_instr.i_fmt.funct3 == F3_WORD)
                begin
                    alu_src    = 1'b1;
                    imm        = {{(XLEN-12){i_instr.i_fmt.imm12[11]}}, i_instr.i_fmt.imm12};
                    mem_to_reg = 1'b1;
                    reg_write  = 1'b1;
                    use_rs1    = 1'b1;
                end
            end
            OPC_STORE:
            begin
                if (i_instr.r_fmt.funct3 == F3_WORD)
                begin
                    alu_src   = 1'b1;
                    // S-type offset is split around rd
                    imm       = {{(XLEN-12){i_instr.r_fmt.funct7[6]}}, i_instr.r_fmt.funct7,
                                 i_instr.r_fmt.rd};
                    mem_write = 1'b1;
                    use_rs1   = 1'b1;
                    use_rs2   = 1'b1;
                end
            end
            // the halt word retires nothing
            OPC_JAL:
            begin
                reg_write = 1'b0;
            end
            default:
            begin
                reg_write = 1'b0;
            end
        endcase
    end

    assign rs1      = use_rs1 ? i_instr.r_fmt.rs1 : 5'd0;
    assign rs2      = use_rs2 ? i_instr.r_fmt.rs2 : 5'd0;
    assign rd       = reg_write ? i_instr.r_fmt.rd : 5'd0;
    assign rs1_data = read_reg(rs1);
    assign rs2_data = read_reg(rs2);

    // Load in EX feeding a source here
    assign o_stall = id_ex.mem_to_reg && id_ex.rd != 5'd0 &&
                     (rs1 == id_ex.rd || rs2 == id_ex.rd);

    always_ff @(posedge clk)
    begin
        if (!i_rst_n)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (i_wb_valid)
        begin
            regs[i_wb_rd] <= i_wb_data;
        end
    end

    // ID/EX register with bubble on stall
    always_ff @(posedge clk)
    begin
        if (!i_rst_n || o_stall)
        begin
            id_ex.alu_op     <= ALU_ADD;
            id_ex.alu_src    <= 1'b0;
            id_ex.mem_write  <= 1'b0;
            id_ex.mem_to_reg <= 1'b0;
            id_ex.reg_write  <= 1'b0;
        end
        else
        begin
            id_ex.alu_op     <= alu_op;
            id_ex.alu_src    <= alu_src;
            id_ex.mem_write  <= mem_write;
            id_ex.mem_to_reg <= mem_to_reg;
            id_ex.reg_write  <= reg_write;
        end
        id_ex.rs1_data <= rs1_data;
        id_ex.rs2_data <= rs2_data;
        id_ex.imm      <= imm;
        id_ex.rs1      <= rs1;
        id_ex.rs2      <= rs2;
        id_ex.rd       <= rd;
    end

    always_ff @(posedge clk)
    begin
        if (!i_rst_n)
        begin
            drain_cnt <= '0;
            o_halted  <= 1'b0;
        end
        else if (i_halt_seen && !o_halted)
        begin
            if (drain_cnt == CNT_W'(DRAIN_CYCLES - 1))
                o_halted <= 1'b1;
            else
                drain_cnt <= drain_cnt + 1'b1;
        end
    end

    x0_never_written: assert property (@(posedge clk) disable iff (!i_rst_n)
        regs[0] == '0);

    stall_single_cycle: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_stall |=> !o_stall);

    // Instructions arrive in PC order with no gaps
    pc_in_order: assert property (@(posedge clk) disable iff (!i_rst_n)
        !$stable(i_pc) |-> i_pc == $past(i_pc) + XLEN'(4));

endmodule

`default_nettype wire

/* fetch_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_stage #(
    parameter int IMEM_DEPTH = 64
) (
    input  logic                          clk,
    input  logic                          i_rst_n,
    input  logic                          i_imem_we,
    input  logic [$clog2(IMEM_DEPTH)-1:0] i_imem_addr,
    input  logic [rv_isa_pkg::XLEN-1:0]   i_imem_data,
    input  logic                          i_start,
    input  logic                          i_stall,
    output rv_isa_pkg::instr_word_t       o_instr,
    output logic [rv_isa_pkg::XLEN-1:0]   o_pc,
    output logic                          o_halt_seen
);
    import rv_isa_pkg::*;

    localparam int IADDR_W = $clog2(IMEM_DEPTH);

    logic [XLEN-1:0] imem [IMEM_DEPTH];
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] fetch_word;
    logic            running;

    assign fetch_word = imem[pc[IADDR_W+1:2]];

    // Program load only while idle
    always_ff @(posedge clk)
    begin
        if (i_imem_we && !running)
            imem[i_imem_addr] <= i_imem_data;
    end

    // Halted is running with o_halt_seen set
    always_ff @(posedge clk)
    begin
        if (!i_rst_n)
        begin
            running     <= 1'b0;
            o_halt_seen <= 1'b0;
            pc          <= '0;
            o_pc        <= '0;
            o_instr     <= NOOP;
        end
        else if (!running)
        begin
            running <= i_start;
        end
        else if (!i_stall && !o_halt_seen)
        begin
            o_instr <= fetch_word;
            o_pc    <= pc;
            pc      <= pc + XLEN'(4);
            if (fetch_word == HALT_INSTR)
                o_halt_seen <= 1'b1;
        end
    end

    imem_write_idle: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_imem_we |-> !running);

endmodule

`default_nettype wire

/* pipe_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface id_ex_bus_if;
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    logic [XLEN-1:0]     rs1_data;
    logic [XLEN-1:0]     rs2_data;
    logic [XLEN-1:0]     imm;
    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [4:0]          rd;
    logic [ALU_OP_W-1:0] alu_op;
    logic                alu_src;
    logic                mem_write;
    logic                mem_to_reg;
    logic                reg_write;

    modport producer (
        output rs1_data, rs2_data, imm, rs1, rs2, rd,
        output alu_op, alu_src, mem_write, mem_to_reg, reg_write
    );

    modport consumer (
        input rs1_data, rs2_data, imm, rs1, rs2, rd,
        input alu_op, alu_src, mem_write, mem_to_reg, reg_write
    );
endinterface

interface ex_mem_bus_if;
    import rv_isa_pkg::*;

    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] store_data;
    logic [4:0]      rd;
    logic            mem_write;
    logic            mem_to_reg;
    logic            reg_write;

    modport producer (
        output alu_result, store_data, rd, mem_write, mem_to_reg, reg_write
    );

    modport consumer (
        input alu_result, store_data, rd, mem_write, mem_to_reg, reg_write
    );
endinterface

`default_nettype wire

/* pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

    localparam int ALU_OP_W = 3;

    localparam logic [ALU_OP_W-1:0] ALU_ADD    = 3'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB    = 3'd1;
    localparam logic [ALU_OP_W-1:0] ALU_AND    = 3'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OR     = 3'd3;
    localparam logic [ALU_OP_W-1:0] ALU_XOR    = 3'd4;
    localparam logic [ALU_OP_W-1:0] ALU_SLT    = 3'd5;
    localparam logic [ALU_OP_W-1:0] ALU_PASS_B = 3'd6;

    // Halt in decode until every older instruction has written back
    localparam int DRAIN_CYCLES = 3;

endpackage

`default_nettype wire

/* rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    localparam int XLEN = 32;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_WORD = 3'b010;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    // addi x0,x0,0
    localparam logic [XLEN-1:0] NOOP       = 32'h0000_0013;
    // jal x0,0 marks end of program
    localparam logic [XLEN-1:0] HALT_INSTR = 32'h0000_006f;

    // One word in R-type or I-type view
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
    } instr_word_t;

endpackage

`default_nettype wire
